/* logic/chi_params.svh */
// Widths, depths and opcode values shared by the CHI retry monitor
`ifndef CHI_PARAMS_SVH
`define CHI_PARAMS_SVH

//--------------------------------------------------------------------------
// Field widths and table sizing
//--------------------------------------------------------------------------
`define CHI_NODE_W       2
`define CHI_NUM_NODES    4
`define CHI_TXN_W        8
`define CHI_PCRD_W       2
`define CHI_NUM_PCRD     (1 << `CHI_PCRD_W)
`define CHI_TABLE_DEPTH  8
`define CHI_GRANT_CNT_W  4
`define CHI_LIVE_CNT_W   4

// Opcode field widths per channel
`define CHI_REQ_OP_W     6
`define CHI_RSP_OP_W     4
`define CHI_DAT_OP_W     3

//--------------------------------------------------------------------------
// Opcode values
//--------------------------------------------------------------------------
`define CHI_RSP_COMP       4'h4
`define CHI_RSP_RETRYACK   4'h3
`define CHI_RSP_PCRDGRANT  4'h7

`define CHI_REQ_PCRDRETURN 6'h05

`define CHI_DAT_COMPDATA   3'h4

`endif

/* logic/chiFlitPkg.sv */
// CHI flit channel types
// Request, response and read data flits as the monitor samples them
`include "chi_params.svh"

package chiFlitPkg;

  // Request channel, target node taken straight from tgtId
  typedef struct packed {
    logic                       valid;
    logic [`CHI_NODE_W-1:0]     tgtId;
    logic [`CHI_TXN_W-1:0]      txnId;
    logic [`CHI_REQ_OP_W-1:0]   opcode;
    logic                       allowRetry;
  } reqFlitT;

  // Response channel
  // pcrdType only carries meaning for RetryAck and PCrdGrant
  typedef struct packed {
    logic                       valid;
    logic [`CHI_NODE_W-1:0]     srcId;
    logic [`CHI_TXN_W-1:0]      txnId;
    logic [`CHI_RSP_OP_W-1:0]   opcode;
    logic [`CHI_PCRD_W-1:0]     pcrdType;
  } rspFlitT;

  // Read data channel, payload not needed here
  typedef struct packed {
    logic                       valid;
    logic [`CHI_NODE_W-1:0]     srcId;
    logic [`CHI_TXN_W-1:0]      txnId;
    logic [`CHI_DAT_OP_W-1:0]   opcode;
  } datFlitT;

endpackage

/* logic/retryTrackPkg.sv */
// Retry tracking types
// Table entries, credit events and per-node count vectors
`include "chi_params.svh"

package retryTrackPkg;

  // One outstanding retry-capable request
  typedef struct packed {
    logic [`CHI_NODE_W-1:0]     node;
    logic [`CHI_TXN_W-1:0]      txnId;
    logic                       retried;
    logic [`CHI_PCRD_W-1:0]     pcrdType;
  } tableEntryT;

  // Single-cycle credit ledger update
  typedef struct packed {
    logic                       valid;
    logic [`CHI_NODE_W-1:0]     node;
    logic [`CHI_PCRD_W-1:0]     pcrdType;
  } creditEventT;

  // Indexed as [node][pcrdType]
  typedef logic [`CHI_NUM_NODES-1:0][`CHI_NUM_PCRD-1:0] nodeTypeMaskT;

  // One count per node
  typedef logic [`CHI_NUM_NODES-1:0][`CHI_LIVE_CNT_W-1:0] nodeCountT;

endpackage

/* logic/txnTable.sv */
// In-order table of outstanding retry-capable requests
// Matches Comp, CompData, RetryAck and PCrdGrant, compacts and appends
`timescale 1ns/1ns
`include "chi_params.svh"

module txnTable
(
  input  logic                         SCLK,
  input  logic                         SRESETn,
  input  chiFlitPkg::reqFlitT          reqFlit_i,
  input  chiFlitPkg::rspFlitT          rspFlit_i,
  input  chiFlitPkg::datFlitT          datFlit_i,
  input  retryTrackPkg::nodeTypeMaskT  grantAvail_i,
  output retryTrackPkg::creditEventT   creditAdd_o,
  output retryTrackPkg::creditEventT   creditUse_o,
  output retryTrackPkg::nodeCountT     liveCount_o,
  output logic                         tableFull_o,
  output logic [`CHI_LIVE_CNT_W-1:0]   outstanding_o
);

  localparam int Depth = `CHI_TABLE_DEPTH;

  retryTrackPkg::tableEntryT entryQ [Depth];
  retryTrackPkg::tableEntryT entryPre [Depth];
  retryTrackPkg::tableEntryT entryShift [Depth];
  retryTrackPkg::tableEntryT entryNext [Depth];
  retryTrackPkg::tableEntryT newEntry;
  logic [Depth-1:0]          allocQ;
  logic [Depth-1:0]          allocShift;
  logic [Depth-1:0]          allocNext;
  logic [Depth-1:0]          rspTxnMatch;
  logic [Depth-1:0]          datMatch;
  logic [Depth-1:0]          grantMatch;
  logic [Depth-1:0]          rspOldest;
  logic [Depth-1:0]          datOldest;
  logic [Depth-1:0]          grantOldest;
  logic [Depth-1:0]          removeVec;
  logic [Depth-1:0]          freeSlot;
  logic [1:0]                shiftAmt [Depth];
  logic                      isComp;
  logic                      isRetry;
  logic                      isGrant;
  logic                      isCompData;
  logic                      reqPush;
  logic                      useGrant;

  // Lowest set bit, slot 0 holds the oldest entry
  function automatic logic [Depth-1:0] oldestOf(input logic [Depth-1:0] vec);
    return vec & (~vec + 1'b1);
  endfunction

  //--------------------------------------------------------------------------
  // Flit decode
  //--------------------------------------------------------------------------
  assign isComp     = rspFlit_i.valid && (rspFlit_i.opcode == `CHI_RSP_COMP);
  assign isRetry    = rspFlit_i.valid && (rspFlit_i.opcode == `CHI_RSP_RETRYACK);
  assign isGrant    = rspFlit_i.valid && (rspFlit_i.opcode == `CHI_RSP_PCRDGRANT);
  assign isCompData = datFlit_i.valid && (datFlit_i.opcode == `CHI_DAT_COMPDATA);
  assign reqPush    = reqFlit_i.valid && reqFlit_i.allowRetry && (reqFlit_i.opcode != '0) &&
                      (reqFlit_i.opcode != `CHI_REQ_PCRDRETURN);

  assign newEntry = '{node: reqFlit_i.tgtId, txnId: reqFlit_i.txnId,
                      retried: 1'b0, pcrdType: '0};

  // Per-slot match against current state
  always_comb
  begin
    for (int i = 0; i < Depth; i++)
    begin
      rspTxnMatch[i] = allocQ[i] && !entryQ[i].retried &&
                       (entryQ[i].node == rspFlit_i.srcId) &&
                       (entryQ[i].txnId == rspFlit_i.txnId);
      datMatch[i]    = allocQ[i] && !entryQ[i].retried &&
                       (entryQ[i].node == datFlit_i.srcId) &&
                       (entryQ[i].txnId == datFlit_i.txnId);
      grantMatch[i]  = allocQ[i] && entryQ[i].retried &&
                       (entryQ[i].node == rspFlit_i.srcId) &&
                       (entryQ[i].pcrdType == rspFlit_i.pcrdType);
    end
  end

  assign rspOldest   = oldestOf(rspTxnMatch);
  assign datOldest   = oldestOf(datMatch);
  assign grantOldest = oldestOf(grantMatch);

  // RetryAck consumes a stored grant when one is waiting
  assign useGrant = isRetry && (|rspTxnMatch) &&
                    grantAvail_i[rspFlit_i.srcId][rspFlit_i.pcrdType];

  // One removal per channel, so at most two bits
  assign removeVec = ({Depth{isComp || useGrant}} & rspOldest) |
                     ({Depth{isGrant}} & grantOldest) |
                     ({Depth{isCompData}} & datOldest);

  // Retry marking before compaction
  always_comb
  begin
    for (int i = 0; i < Depth; i++)
    begin
      entryPre[i] = entryQ[i];
      if (isRetry && !useGrant && rspOldest[i])
      begin
        entryPre[i].retried  = 1'b1;
        entryPre[i].pcrdType = rspFlit_i.pcrdType;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Compaction toward slot 0
  //--------------------------------------------------------------------------
  always_comb
  begin
    logic [Depth+1:0] removePad;
    logic [1:0]       acc;
    removePad = {2'b00, removeVec};
    acc = '0;
    for (int i = 0; i < Depth; i++)
    begin
      // Skip up to two removed sources
      if (removePad[i + acc])
        acc = acc + 1'b1;
      if (removePad[i + acc])
        acc = acc + 1'b1;
      shiftAmt[i] = acc;
    end
  end

  always_comb
  begin
    int src;
    for (int i = 0; i < Depth; i++)
    begin
      src = i + shiftAmt[i];
      entryShift[i] = entryPre[i];
      allocShift[i] = 1'b0;
      if (src < Depth)
      begin
        entryShift[i] = entryPre[src];
        allocShift[i] = allocQ[src];
      end
    end
  end

  // New request lands in the first free slot, dropped when full
  assign freeSlot = oldestOf(~allocShift);

  always_comb
  begin
    for (int i = 0; i < Depth; i++)
    begin
      entryNext[i] = entryShift[i];
      allocNext[i] = allocShift[i];
      if (reqPush && freeSlot[i])
      begin
        entryNext[i] = newEntry;
        allocNext[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge SCLK)
  begin
    if (!SRESETn)
    begin
      allocQ <= '0;
    end
    else
    begin
      allocQ <= allocNext;
    end
  end

  always_ff @(posedge SCLK)
  begin
    entryQ <= entryNext;
  end

  //--------------------------------------------------------------------------
  // Status and credit events
  //--------------------------------------------------------------------------
  always_comb
  begin
    outstanding_o = '0;
    liveCount_o   = '0;
    for (int i = 0; i < Depth; i++)
    begin
      if (allocQ[i])
        outstanding_o = outstanding_o + 1'b1;
      if (allocQ[i] && !entryQ[i].retried)
        liveCount_o[entryQ[i].node] = liveCount_o[entryQ[i].node] + 1'b1;
    end
  end

  assign tableFull_o = &allocQ;

  assign creditAdd_o = '{valid: isGrant && !(|grantMatch), node: rspFlit_i.srcId,
                         pcrdType: rspFlit_i.pcrdType};
  assign creditUse_o = '{valid: useGrant, node: rspFlit_i.srcId,
                         pcrdType: rspFlit_i.pcrdType};

endmodule

/* logic/grantLedger.sv */
// Ledger of unpaired PCrdGrants
// One saturating counter per node and credit type
`timescale 1ns/1ns
`include "chi_params.svh"

module grantLedger
(
  input  logic                         SCLK,
  input  logic                         SRESETn,
  input  retryTrackPkg::creditEventT   creditAdd_i,
  input  retryTrackPkg::creditEventT   creditUse_i,
  output retryTrackPkg::nodeTypeMaskT  grantAvail_o,
  output retryTrackPkg::nodeCountT     grantCount_o
);

  localparam int NumNodes = `CHI_NUM_NODES;
  localparam int NumTypes = `CHI_NUM_PCRD;
  localparam int SumW     = `CHI_GRANT_CNT_W + `CHI_PCRD_W;
  localparam logic [`CHI_GRANT_CNT_W-1:0] CntMax  = '1;
  localparam logic [`CHI_LIVE_CNT_W-1:0]  LiveMax = '1;

  logic [`CHI_GRANT_CNT_W-1:0]  grantCnt [NumNodes][NumTypes];
  retryTrackPkg::nodeTypeMaskT  addMask;
  retryTrackPkg::nodeTypeMaskT  useMask;

  // Event decode to a one-hot node/type mask
  always_comb
  begin
    addMask = '0;
    useMask = '0;
    if (creditAdd_i.valid)
      addMask[creditAdd_i.node][creditAdd_i.pcrdType] = 1'b1;
    if (creditUse_i.valid)
      useMask[creditUse_i.node][creditUse_i.pcrdType] = 1'b1;
  end

  always_ff @(posedge SCLK)
  begin
    for (int n = 0; n < NumNodes; n++)
    begin
      for (int t = 0; t < NumTypes; t++)
      begin
        if (!SRESETn)
          grantCnt[n][t] <= '0;
        else if (addMask[n][t] && !useMask[n][t] && (grantCnt[n][t] != CntMax))
          grantCnt[n][t] <= grantCnt[n][t] + 1'b1;
        else if (useMask[n][t] && !addMask[n][t] && (grantCnt[n][t] != '0))
          grantCnt[n][t] <= grantCnt[n][t] - 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Non-zero mask and per-node sums
  //--------------------------------------------------------------------------
  always_comb
  begin
    logic [SumW-1:0] sum;
    for (int n = 0; n < NumNodes; n++)
    begin
      sum = '0;
      for (int t = 0; t < NumTypes; t++)
      begin
        grantAvail_o[n][t] = (grantCnt[n][t] != '0);
        sum = sum + SumW'(grantCnt[n][t]);
      end
      // Clamp to the count width
      grantCount_o[n] = (sum > LiveMax) ? LiveMax : sum[`CHI_LIVE_CNT_W-1:0];
    end
  end

endmodule

/* logic/speculationCheck.sv */
// Speculative PCrdGrant check
// Flags a node holding more unpaired grants than live requests
`timescale 1ns/1ns
`include "chi_params.svh"

module speculationCheck
(
  input  logic                       SCLK,
  input  logic                       SRESETn,
  input  retryTrackPkg::nodeCountT   liveCount_i,
  input  retryTrackPkg::nodeCountT   grantCount_i,
  output logic [`CHI_NUM_NODES-1:0]  specErr_o
);

  localparam int NumNodes = `CHI_NUM_NODES;

  logic [NumNodes-1:0] overBound;

  // Grants beyond the requests that could still be retried
  always_comb
  begin
    for (int n = 0; n < NumNodes; n++)
    begin
      overBound[n] = (grantCount_i[n] > liveCount_i[n]);
    end
  end

  // Flag follows the counts, so it drops once they are back in bounds
  always_ff @(posedge SCLK)
  begin
    if (!SRESETn)
    begin
      specErr_o <= '0;
    end
    else
    begin
      specErr_o <= overBound;
    end
  end

endmodule

/* logic/chiRetryMonitor.sv */
// CHI retry and protocol-credit monitor, requester side
// Request table, grant ledger and speculation check
`timescale 1ns/1ns
`include "chi_params.svh"

module chiRetryMonitor
(
  input  logic                        SCLK,
  input  logic                        SRESETn,
  input  chiFlitPkg::reqFlitT         reqFlit_i,
  input  chiFlitPkg::rspFlitT         rspFlit_i,
  input  chiFlitPkg::datFlitT         datFlit_i,
  output logic [`CHI_NUM_NODES-1:0]   specErr_o,
  output logic                        tableFull_o,
  output logic [`CHI_LIVE_CNT_W-1:0]  outstanding_o
);

  retryTrackPkg::creditEventT   creditAdd;
  retryTrackPkg::creditEventT   creditUse;
  retryTrackPkg::nodeTypeMaskT  grantAvail;
  retryTrackPkg::nodeCountT     liveCount;
  retryTrackPkg::nodeCountT     grantCount;

  txnTable uTxnTable
  (
    .SCLK          (SCLK),
    .SRESETn       (SRESETn),
    .reqFlit_i     (reqFlit_i),
    .rspFlit_i     (rspFlit_i),
    .datFlit_i     (datFlit_i),
    .grantAvail_i  (grantAvail),
    .creditAdd_o   (creditAdd),
    .creditUse_o   (creditUse),
    .liveCount_o   (liveCount),
    .tableFull_o   (tableFull_o),
    .outstanding_o (outstanding_o)
  );

  // Grants that arrived ahead of their RetryAck
  grantLedger uGrantLedger
  (
    .SCLK          (SCLK),
    .SRESETn       (SRESETn),
    .creditAdd_i   (creditAdd),
    .creditUse_i   (creditUse),
    .grantAvail_o  (grantAvail),
    .grantCount_o  (grantCount)
  );

  speculationCheck uSpeculationCheck
  (
    .SCLK          (SCLK),
    .SRESETn       (SRESETn),
    .liveCount_i   (liveCount),
    .grantCount_i  (grantCount),
    .specErr_o     (specErr_o)
  );

endmodule

/* test/chiRetry_assert.sv */
// Concurrent checks bound into the CHI retry monitor
// Credit event exclusivity, full-table count and specErr under reset
`timescale 1ns/1ns
`include "chi_params.svh"

module chiRetryAssert
(
  input logic                        SCLK,
  input logic                        SRESETn,
  input retryTrackPkg::creditEventT  creditAdd_i,
  input retryTrackPkg::creditEventT  creditUse_i,
  input logic                        tableFull_i,
  input logic [`CHI_LIVE_CNT_W-1:0]  outstanding_i,
  input logic [`CHI_NUM_NODES-1:0]   specErr_i
);

  localparam logic [`CHI_LIVE_CNT_W-1:0] FullCount = `CHI_TABLE_DEPTH;

  // Number of assertion failures
  int failCount = 0;

  // Grant stored or consumed in a cycle but not both
  creditExclusive: assert property (
    @(posedge SCLK) disable iff (!SRESETn)
    !(creditAdd_i.valid && creditUse_i.valid))
  else
  begin
    failCount++;
    $error("creditAdd and creditUse pulsed in the same cycle");
  end

  // Full flag only with every slot allocated
  fullMeansDepth: assert property (
    @(posedge SCLK) disable iff (!SRESETn)
    tableFull_i |-> (outstanding_i == FullCount))
  else
  begin
    failCount++;
    $error("tableFull set while outstanding is not the table depth");
  end

  // Synchronous reset clears the error flags
  specErrInReset: assert property (
    @(posedge SCLK)
    !SRESETn |=> (specErr_i == '0))
  else
  begin
    failCount++;
    $error("specErr not cleared by reset");
  end

endmodule

/* test/chiRetryTb.sv */
// Directed testbench for the CHI retry and protocol-credit monitor
// Completion, table fill and retry/grant pairing with speculation checks
`timescale 1ns/1ns
`include "chi_params.svh"

module chiRetryTb;

  typedef logic [`CHI_NODE_W-1:0]    nodeT;
  typedef logic [`CHI_TXN_W-1:0]     txnT;
  typedef logic [`CHI_PCRD_W-1:0]    pcrdT;
  typedef logic [`CHI_NUM_NODES-1:0] nodeMaskT;

  // Limit sits far above the summed length of the directed tests
  localparam int TimeoutCycles = 400;
  localparam int ResetCycles   = 8;
  localparam logic [`CHI_REQ_OP_W-1:0] ReqOpRead = 6'h01;

  logic                        SCLK;
  logic                        SRESETn;
  chiFlitPkg::reqFlitT         reqFlit;
  chiFlitPkg::rspFlitT         rspFlit;
  chiFlitPkg::datFlitT         datFlit;
  nodeMaskT                    specErr;
  logic                        tableFull;
  logic [`CHI_LIVE_CNT_W-1:0]  outstanding;
  int                          cycleCount;
  int                          checkCount;
  int                          errorCount;

  chiRetryMonitor uut
  (
    .SCLK          (SCLK),
    .SRESETn       (SRESETn),
    .reqFlit_i     (reqFlit),
    .rspFlit_i     (rspFlit),
    .datFlit_i     (datFlit),
    .specErr_o     (specErr),
    .tableFull_o   (tableFull),
    .outstanding_o (outstanding)
  );

  bind chiRetryMonitor chiRetryAssert uMonitorAssert
  (
    .SCLK          (SCLK),
    .SRESETn       (SRESETn),
    .creditAdd_i   (creditAdd),
    .creditUse_i   (creditUse),
    .tableFull_i   (tableFull_o),
    .outstanding_i (outstanding_o),
    .specErr_i     (specErr_o)
  );

  always #5 SCLK = ~SCLK;

  // Watchdog
  always @(posedge SCLK)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------------
  task automatic clearFlits();
    reqFlit = '0;
    rspFlit = '0;
    datFlit = '0;
  endtask

  // One rising edge samples the channels, then they go idle
  task automatic stepCycle();
    @(negedge SCLK);
    clearFlits();
  endtask

  task automatic applyReset();
    SRESETn = 1'b0;
    clearFlits();
    repeat (ResetCycles) @(negedge SCLK);
    SRESETn = 1'b1;
  endtask

  task automatic putReq(input nodeT node, input txnT txn,
                        input logic [`CHI_REQ_OP_W-1:0] opcode, input logic allowRetry);
    reqFlit.valid      = 1'b1;
    reqFlit.tgtId      = node;
    reqFlit.txnId      = txn;
    reqFlit.opcode     = opcode;
    reqFlit.allowRetry = allowRetry;
  endtask

  task automatic putRsp(input nodeT node, input txnT txn,
                        input logic [`CHI_RSP_OP_W-1:0] opcode, input pcrdT pcrdType);
    rspFlit.valid    = 1'b1;
    rspFlit.srcId    = node;
    rspFlit.txnId    = txn;
    rspFlit.opcode   = opcode;
    rspFlit.pcrdType = pcrdType;
  endtask

  task automatic putDat(input nodeT node, input txnT txn);
    datFlit.valid  = 1'b1;
    datFlit.srcId  = node;
    datFlit.txnId  = txn;
    datFlit.opcode = `CHI_DAT_COMPDATA;
  endtask

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------
  task automatic checkEq(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic checkOutstanding(input int expected);
    checkEq("outstanding_o", 32'(outstanding), 32'(expected));
  endtask

  task automatic checkFull(input logic expected);
    checkEq("tableFull_o", 32'(tableFull), 32'(expected));
  endtask

  task automatic checkSpecErr(input nodeMaskT expected);
    checkEq("specErr_o", 32'(specErr), 32'(expected));
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------
  task automatic testReset();
    applyReset();
    checkOutstanding(0);
    checkFull(1'b0);
    checkSpecErr('0);
  endtask

  task automatic testCompletion();
    nodeT node;
    txnT  txnBase;
    applyReset();
    node    = nodeT'($urandom());
    txnBase = txnT'($urandom());
    for (int i = 0; i < 3; i++)
    begin
      putReq(node, txnBase + txnT'(i), ReqOpRead, 1'b1);
      stepCycle();
      checkOutstanding(i + 1);
    end
    // No retry allowed, PCrdReturn and a null opcode
    putReq(node, txnBase + 8'd3, ReqOpRead, 1'b0);
    stepCycle();
    putReq(node, txnBase + 8'd4, `CHI_REQ_PCRDRETURN, 1'b1);
    stepCycle();
    putReq(node, txnBase + 8'd5, '0, 1'b1);
    stepCycle();
    checkOutstanding(3);
    // Two removals in one cycle
    putRsp(node, txnBase, `CHI_RSP_COMP, '0);
    putDat(node, txnBase + 8'd1);
    stepCycle();
    checkOutstanding(1);
    stepCycle();
    checkSpecErr('0);
  endtask

  task automatic testFill();
    nodeT firstNode;
    nodeT node;
    txnT  txnBase;
    applyReset();
    txnBase   = txnT'($urandom());
    firstNode = '0;
    for (int i = 0; i < `CHI_TABLE_DEPTH; i++)
    begin
      node = nodeT'($urandom());
      if (i == 0)
        firstNode = node;
      putReq(node, txnBase + txnT'(i), ReqOpRead, 1'b1);
      stepCycle();
      checkOutstanding(i + 1);
      checkFull(i == `CHI_TABLE_DEPTH - 1);
    end
    // Ninth request finds no slot
    putReq(firstNode, txnBase + 8'd8, ReqOpRead, 1'b1);
    stepCycle();
    checkOutstanding(`CHI_TABLE_DEPTH);
    putRsp(firstNode, txnBase, `CHI_RSP_COMP, '0);
    stepCycle();
    checkFull(1'b0);
    checkOutstanding(`CHI_TABLE_DEPTH - 1);
    // Comp for the dropped request matches nothing
    putRsp(firstNode, txnBase + 8'd8, `CHI_RSP_COMP, '0);
    stepCycle();
    checkOutstanding(`CHI_TABLE_DEPTH - 1);
  endtask

  task automatic testRetryThenGrant();
    nodeT     node;
    pcrdT     pcrd;
    pcrdT     wrongType;
    txnT      txnA;
    nodeMaskT specMask;
    applyReset();
    node      = nodeT'($urandom());
    pcrd      = pcrdT'($urandom());
    wrongType = pcrd + 2'd1;
    txnA      = txnT'($urandom());
    specMask  = nodeMaskT'(1) << node;
    putReq(node, txnA, ReqOpRead, 1'b1);
    stepCycle();
    checkOutstanding(1);
    putRsp(node, txnA, `CHI_RSP_RETRYACK, pcrd);
    stepCycle();
    checkOutstanding(1);
    stepCycle();
    checkSpecErr('0);
    // Wrong credit type goes to the ledger
    putRsp(node, '0, `CHI_RSP_PCRDGRANT, wrongType);
    stepCycle();
    checkOutstanding(1);
    checkSpecErr('0);
    stepCycle();
    checkSpecErr(specMask);
    putRsp(node, '0, `CHI_RSP_PCRDGRANT, pcrd);
    stepCycle();
    checkOutstanding(0);
    stepCycle();
    checkSpecErr(specMask);
  endtask

  task automatic testGrantThenRetry();
    nodeT     node;
    pcrdT     pcrd;
    txnT      txnA;
    nodeMaskT specMask;
    applyReset();
    node     = nodeT'($urandom());
    pcrd     = pcrdT'($urandom());
    txnA     = txnT'($urandom());
    specMask = nodeMaskT'(1) << node;
    putReq(node, txnA, ReqOpRead, 1'b1);
    stepCycle();
    checkOutstanding(1);
    // Grant covered by the one live request
    putRsp(node, '0, `CHI_RSP_PCRDGRANT, pcrd);
    stepCycle();
    checkOutstanding(1);
    stepCycle();
    checkSpecErr('0);
    putRsp(node, txnA, `CHI_RSP_RETRYACK, pcrd);
    stepCycle();
    checkOutstanding(0);
    stepCycle();
    checkSpecErr('0);
    // Grant with nothing outstanding to the node
    putRsp(node, '0, `CHI_RSP_PCRDGRANT, pcrd);
    stepCycle();
    checkSpecErr('0);
    stepCycle();
    checkSpecErr(specMask);
  endtask

  initial
  begin
    SCLK       = 1'b0;
    SRESETn    = 1'b0;
    cycleCount = 0;
    checkCount = 0;
    errorCount = 0;
    clearFlits();
    void'($urandom(32'he1fd));
    testReset();
    testCompletion();
    testFill();
    testRetryThenGrant();
    testGrantThenRetry();
    if (uut.uMonitorAssert.failCount != 0)
    begin
      $display("Bound assertions failed %0d times", uut.uMonitorAssert.failCount);
      errorCount = errorCount + uut.uMonitorAssert.failCount;
    end
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+logic
logic/chiFlitPkg.sv
logic/retryTrackPkg.sv
logic/txnTable.sv
logic/grantLedger.sv
logic/speculationCheck.sv
logic/chiRetryMonitor.sv
test/chiRetry_assert.sv
test/chiRetryTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
TOP       ?= chiRetryTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
